//--- all.f
verilog/conv_code_pkg.sv
verilog/symbol_map_pkg.sv
verilog/coded_pair_if.sv
verilog/word_unpacker.sv
verilog/conv_encoder.sv
verilog/pair_puncturer.sv
verilog/symbol_mapper.sv
verilog/qpsk_encoder_top.sv
testbench/tb_qpsk_encoder.sv

//--- Makefile
# Verilator build and run for the QPSK convolutional encoder testbench

VERILATOR ?= verilator
TOP       ?= tb_qpsk_encoder
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench prints its pass line
run: compile
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_qpsk_encoder.sv
/*
  Testbench for the rate-3/4 QPSK encoder that checks directed streams
  against a reference model of bit order, encoding, puncturing and mapping
*/
`timescale 1ns/1ps

module tb_qpsk_encoder;

  localparam int K              = 7;
  localparam int RESET_CYCLES   = 8;
  localparam int STREAM_WORDS   = 6;
  localparam int CLEAR_LEAD     = 3;          // Words sent before the clear
  localparam int TOTAL_WORDS    = 5 * STREAM_WORDS + CLEAR_LEAD;
  localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 32 * 4 + 200;

  localparam logic [K-1:0] G_UPPER       = 7'b1011011;
  localparam logic [K-1:0] G_LOWER       = 7'b1111001;
  localparam logic [5:0]   PUNCT_PATTERN = 6'b110110;

  // QPSK points with I in the upper half
  localparam symbol_map_pkg::sample_t TABLE_VALUES [4] =
    '{32'h2d41_2d41, 32'h2d41_d2bf, 32'hd2bf_2d41, 32'hd2bf_d2bf};

  logic                      ce_clk;
  logic                      i_rst_n;
  conv_code_pkg::data_word_t i_in_data;
  logic                      i_in_valid;
  logic                      o_in_ready;
  symbol_map_pkg::sample_t   o_out_data;
  logic                      o_out_valid;
  logic                      i_out_ready;
  logic                      i_reverse_bits;
  logic                      i_swap_iq;
  logic                      i_clear;
  logic                      i_lut_we;
  symbol_map_pkg::sym_t      i_lut_addr;
  symbol_map_pkg::sample_t   i_lut_data;

  // Reference model state
  logic [K-1:0]              enc_reg;
  int                        warm_bits;
  logic [2:0]                punct_pos;
  logic                      have_first;
  logic                      first_kept;
  symbol_map_pkg::sample_t   lut_model [4];
  symbol_map_pkg::sample_t   exp_q [$];

  conv_code_pkg::data_word_t words [16];
  integer                    seed;
  logic [31:0]               rnd;
  logic                      bp_on;
  logic                      use_bp;
  logic                      held;
  symbol_map_pkg::sample_t   held_data;
  symbol_map_pkg::sample_t   exp_sample;
  int                        cycle_cnt;

  qpsk_encoder_top dut_i (
    .ce_clk         (ce_clk),
    .i_rst_n        (i_rst_n),
    .i_in_data      (i_in_data),
    .i_in_valid     (i_in_valid),
    .o_in_ready     (o_in_ready),
    .o_out_data     (o_out_data),
    .o_out_valid    (o_out_valid),
    .i_out_ready    (i_out_ready),
    .i_reverse_bits (i_reverse_bits),
    .i_swap_iq      (i_swap_iq),
    .i_clear        (i_clear),
    .i_lut_we       (i_lut_we),
    .i_lut_addr     (i_lut_addr),
    .i_lut_data     (i_lut_data)
  );

  initial begin
    ce_clk = 1'b0;
    forever #50 ce_clk = ~ce_clk;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp)
      else stop_on_error($sformatf("** Error: %s got %h expected %h", name, got, exp));
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic void restart_model();
    enc_reg    = '0;
    warm_bits  = 0;
    punct_pos  = 3'd5;
    have_first = 1'b0;
    first_kept = 1'b0;
    exp_q.delete();
  endfunction

  function automatic void map_kept_bit(input logic b);
    symbol_map_pkg::sym_t sym;
    if (!have_first) begin
      first_kept = b;
      have_first = 1'b1;
    end else begin
      sym = i_swap_iq ? {b, first_kept} : {first_kept, b};  // First bit is the MSB unless swapped
      exp_q.push_back(lut_model[sym]);
      have_first = 1'b0;
    end
  endfunction

  function automatic void puncture_bit(input logic b);
    logic keep;
    keep      = PUNCT_PATTERN[punct_pos];
    punct_pos = (punct_pos == 3'd0) ? 3'd5 : punct_pos - 3'd1;
    if (keep) map_kept_bit(b);
  endfunction

  function automatic void shift_in_bit(input logic b);
    enc_reg = {enc_reg[K-2:0], b};
    if (warm_bits < K - 1) begin
      warm_bits++;                            // Register still filling
    end else begin
      puncture_bit(^(enc_reg & G_UPPER));     // Upper goes first
      puncture_bit(^(enc_reg & G_LOWER));
    end
  endfunction

  function automatic void encode_word(input conv_code_pkg::data_word_t w);
    for (int n = 0; n < 32; n++) begin
      if (i_reverse_bits) shift_in_bit(w[n]);
      else shift_in_bit(w[31-n]);
    end
  endfunction

  ////////////////////
  // Output side
  ////////////////////

  // Random back-pressure while a test asks for it
  initial begin
    i_out_ready = 1'b1;
    forever begin
      @(posedge ce_clk);
      use_bp = bp_on;
      #1;
      if (use_bp) begin
        rnd         = $random(seed);
        i_out_ready = rnd[0];
      end else begin
        i_out_ready = 1'b1;
      end
    end
  end

  // Compare every transferred sample and watch stalled samples hold
  always @(posedge ce_clk) begin
    if (!i_rst_n || i_clear) begin
      held = 1'b0;
    end else begin
      if (held) begin
        assert (o_out_valid === 1'b1)
          else stop_on_error("o_out_valid dropped before the sample was taken");
        assert (o_out_data === held_data)
          else stop_on_error($sformatf("** Error: o_out_data got %08h expected %08h in a stall",
                                       o_out_data, held_data));
      end
      if (o_out_valid === 1'b1 && i_out_ready === 1'b1) begin
        assert (exp_q.size() != 0)
          else stop_on_error("An output sample arrived when none was expected");
        if (exp_q.size() != 0) begin
          exp_sample = exp_q.pop_front();
          assert (o_out_data === exp_sample)
            else stop_on_error($sformatf("** Error: o_out_data got %08h expected %08h",
                                         o_out_data, exp_sample));
        end
      end
      held      = o_out_valid && !i_out_ready;
      held_data = o_out_data;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge ce_clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "Run stopped by the cycle limit");
  end

  ////////////////////
  // Stimulus tasks
  ////////////////////

  task automatic write_table();
    for (int n = 0; n < 4; n++) begin
      i_lut_we     = 1'b1;
      i_lut_addr   = symbol_map_pkg::sym_t'(n);
      i_lut_data   = TABLE_VALUES[n];
      lut_model[n] = TABLE_VALUES[n];
      @(posedge ce_clk);
      #1;
    end
    i_lut_we = 1'b0;
  endtask

  // One-cycle clear that restarts the model from warm-up
  task automatic clear_pipeline();
    i_clear = 1'b1;
    @(posedge ce_clk);
    #1;
    i_clear = 1'b0;
    restart_model();
    @(posedge ce_clk);
    check_bit("o_in_ready", o_in_ready, 1'b0);
    check_bit("o_out_valid", o_out_valid, 1'b0);
    #1;
  endtask

  task automatic fill_words(input int n);
    for (int i = 0; i < n; i++) words[i] = $random(seed);
  endtask

  task automatic send_word(input conv_code_pkg::data_word_t w);
    encode_word(w);
    i_in_data  = w;
    i_in_valid = 1'b1;
    @(posedge ce_clk);
    while (!o_in_ready) @(posedge ce_clk);
    #1;
    i_in_valid = 1'b0;
  endtask

  task automatic send_words(input int n);
    for (int i = 0; i < n; i++) send_word(words[i]);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge ce_clk);
      #1;
    end
    repeat (8) begin
      @(posedge ce_clk);
      assert (o_out_valid === 1'b0)
        else stop_on_error("A sample was still offered after the stream had drained");
    end
    #1;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset();
    i_rst_n = 1'b0;
    for (int n = 0; n < RESET_CYCLES; n++) begin
      @(posedge ce_clk);
      if (n > 0) check_bit("o_out_valid", o_out_valid, 1'b0);
    end
    #1;
    i_rst_n = 1'b1;
    @(posedge ce_clk);
    check_bit("o_in_ready", o_in_ready, 1'b0);  // Held low in the first cycle
    check_bit("o_out_valid", o_out_valid, 1'b0);
    repeat (4) begin
      @(posedge ce_clk);
      check_bit("o_in_ready", o_in_ready, 1'b1);
      check_bit("o_out_valid", o_out_valid, 1'b0);
    end
    #1;
  endtask

  task automatic test_basic_stream();
    write_table();
    clear_pipeline();
    fill_words(STREAM_WORDS);
    send_words(STREAM_WORDS);
    wait_drain();
  endtask

  task automatic test_reverse_bits();
    i_reverse_bits = 1'b1;
    clear_pipeline();
    fill_words(STREAM_WORDS);
    send_words(STREAM_WORDS);
    wait_drain();
    i_reverse_bits = 1'b0;
  endtask

  task automatic test_swap_iq();
    i_swap_iq = 1'b1;
    clear_pipeline();
    fill_words(STREAM_WORDS);
    send_words(STREAM_WORDS);
    wait_drain();
    i_swap_iq = 1'b0;
  endtask

  task automatic test_backpressure();
    clear_pipeline();
    fill_words(STREAM_WORDS);
    bp_on = 1'b1;
    send_words(STREAM_WORDS);
    wait_drain();
    bp_on = 1'b0;
  endtask

  task automatic test_clear();
    clear_pipeline();
    fill_words(CLEAR_LEAD);
    send_words(CLEAR_LEAD);
    repeat (20) @(posedge ce_clk);            // Stream still in flight
    #1;
    clear_pipeline();
    fill_words(STREAM_WORDS);
    send_words(STREAM_WORDS);
    wait_drain();
  endtask

  initial begin
    seed           = 32'hc658bb14;
    bp_on          = 1'b0;
    held           = 1'b0;
    i_rst_n        = 1'b0;
    i_in_data      = '0;
    i_in_valid     = 1'b0;
    i_reverse_bits = 1'b0;
    i_swap_iq      = 1'b0;
    i_clear        = 1'b0;
    i_lut_we       = 1'b0;
    i_lut_addr     = '0;
    i_lut_data     = '0;
    restart_model();

    test_reset();
    test_basic_stream();
    test_reverse_bits();
    test_swap_iq();
    test_backpressure();
    test_clear();

    $display("TEST OK");
    $finish;
  end

endmodule

//--- verilog/qpsk_encoder_top.sv
/*
  Rate-3/4 convolutional encoder with QPSK mapping, from payload words
  to table-mapped output samples
*/
`timescale 1ns/1ps

module qpsk_encoder_top #(
  parameter conv_code_pkg::code_reg_t  P_G_UPPER   = conv_code_pkg::DEF_G_UPPER,
  parameter conv_code_pkg::code_reg_t  P_G_LOWER   = conv_code_pkg::DEF_G_LOWER,
  parameter conv_code_pkg::punct_vec_t P_PUNCT_VEC = conv_code_pkg::DEF_PUNCT_VEC
) (
  input  logic                      ce_clk,
  input  logic                      i_rst_n,
  // Payload words
  input  conv_code_pkg::data_word_t i_in_data,
  input  logic                      i_in_valid,
  output logic                      o_in_ready,
  // Mapped samples
  output symbol_map_pkg::sample_t   o_out_data,
  output logic                      o_out_valid,
  input  logic                      i_out_ready,
  // Configuration
  input  logic                      i_reverse_bits,
  input  logic                      i_swap_iq,
  input  logic                      i_clear,
  // Sample table write
  input  logic                      i_lut_we,
  input  symbol_map_pkg::sym_t      i_lut_addr,
  input  symbol_map_pkg::sample_t   i_lut_data
);

  logic raw_bit;
  logic raw_bit_valid;
  logic raw_bit_ready;
  logic kept_bit;
  logic kept_bit_valid;
  logic kept_bit_ready;

  coded_pair_if pair_if ();

  word_unpacker unpacker_i (
    .ce_clk         (ce_clk),
    .i_rst_n        (i_rst_n),
    .i_clear        (i_clear),
    .i_reverse_bits (i_reverse_bits),
    .i_data         (i_in_data),
    .i_valid        (i_in_valid),
    .o_ready        (o_in_ready),
    .o_bit          (raw_bit),
    .o_bit_valid    (raw_bit_valid),
    .i_bit_ready    (raw_bit_ready)
  );

  conv_encoder #(
    .P_G_UPPER (P_G_UPPER),
    .P_G_LOWER (P_G_LOWER)
  ) encoder_i (
    .ce_clk      (ce_clk),
    .i_rst_n     (i_rst_n),
    .i_clear     (i_clear),
    .i_bit       (raw_bit),
    .i_bit_valid (raw_bit_valid),
    .o_bit_ready (raw_bit_ready),
    .o_pair      (pair_if.enc)
  );

  pair_puncturer #(
    .P_PUNCT_VEC (P_PUNCT_VEC)
  ) puncturer_i (
    .ce_clk      (ce_clk),
    .i_rst_n     (i_rst_n),
    .i_clear     (i_clear),
    .i_pair      (pair_if.punct),
    .o_bit       (kept_bit),
    .o_bit_valid (kept_bit_valid),
    .i_bit_ready (kept_bit_ready)
  );

  symbol_mapper mapper_i (
    .ce_clk         (ce_clk),
    .i_rst_n        (i_rst_n),
    .i_clear        (i_clear),
    .i_swap_iq      (i_swap_iq),
    .i_bit          (kept_bit),
    .i_bit_valid    (kept_bit_valid),
    .o_bit_ready    (kept_bit_ready),
    .i_lut_we       (i_lut_we),
    .i_lut_addr     (i_lut_addr),
    .i_lut_data     (i_lut_data),
    .o_sample       (o_out_data),
    .o_sample_valid (o_out_valid),
    .i_sample_ready (i_out_ready)
  );

endmodule

//--- verilog/symbol_mapper.sv
/*
  QPSK symbol mapper that pairs kept bits into 2-bit symbols, optionally
  swapping I and Q, and looks each one up in a writable sample table
*/
`timescale 1ns/1ps

module symbol_mapper (
  input  logic                     ce_clk,
  input  logic                     i_rst_n,
  input  logic                     i_clear,
  input  logic                     i_swap_iq,
  input  logic                     i_bit,
  input  logic                     i_bit_valid,
  output logic                     o_bit_ready,
  input  logic                     i_lut_we,
  input  symbol_map_pkg::sym_t     i_lut_addr,
  input  symbol_map_pkg::sample_t  i_lut_data,
  output symbol_map_pkg::sample_t  o_sample,
  output logic                     o_sample_valid,
  input  logic                     i_sample_ready
);

  symbol_map_pkg::sample_t    lut [symbol_map_pkg::LUT_DEPTH];
  symbol_map_pkg::map_state_t state;
  symbol_map_pkg::sym_t       sym;
  symbol_map_pkg::sample_t    sample_q;
  logic                       first_bit;
  logic                       sample_valid;
  logic                       out_free;
  logic                       take_bit;

  assign out_free = !sample_valid || i_sample_ready;

  // The first bit can always be parked while the second needs output room
  assign o_bit_ready = (state == symbol_map_pkg::WAIT_FIRST) || out_free;
  assign take_bit    = i_bit_valid && o_bit_ready;

  assign sym = i_swap_iq ? {i_bit, first_bit} : {first_bit, i_bit};

  ////////////////////
  // Sample table
  ////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_lut_we) lut[i_lut_addr] <= i_lut_data;
  end

  ////////////////////
  // Pairing FSM
  ////////////////////

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n || i_clear) begin
      state        <= symbol_map_pkg::WAIT_FIRST;
      sample_valid <= 1'b0;
    end else begin
      if (i_sample_ready) sample_valid <= 1'b0;
      if (take_bit) begin
        case (state)
          symbol_map_pkg::WAIT_FIRST: begin
            state <= symbol_map_pkg::WAIT_SECOND;
          end
          default: begin
            state        <= symbol_map_pkg::WAIT_FIRST;
            sample_valid <= 1'b1;              // Symbol complete
          end
        endcase
      end
    end
  end

  // Payload registers
  always_ff @(posedge ce_clk) begin
    if (take_bit && state == symbol_map_pkg::WAIT_FIRST) first_bit <= i_bit;
    if (take_bit && state == symbol_map_pkg::WAIT_SECOND) sample_q <= lut[sym];
  end

  assign o_sample       = sample_q;
  assign o_sample_valid = sample_valid;

endmodule

//--- verilog/pair_puncturer.sv
/*
  Puncturer that serializes coded pairs upper bit first and forwards only
  the bits the puncture pattern keeps
*/
`timescale 1ns/1ps

module pair_puncturer #(
  parameter conv_code_pkg::punct_vec_t P_PUNCT_VEC = conv_code_pkg::DEF_PUNCT_VEC
) (
  input  logic        ce_clk,
  input  logic        i_rst_n,
  input  logic        i_clear,
  coded_pair_if.punct i_pair,
  output logic        o_bit,
  output logic        o_bit_valid,
  input  logic        i_bit_ready
);

  // Index restarts from the top of the pattern
  localparam conv_code_pkg::punct_idx_t IDX_TOP =
    conv_code_pkg::punct_idx_t'(2 * conv_code_pkg::PUNCT_RATE - 1);

  conv_code_pkg::punct_idx_t punct_idx;
  logic                      lower_phase;      // Set while the lower bit is next
  logic                      cur_bit;
  logic                      keep_bit;
  logic                      out_free;
  logic                      step;
  logic                      out_bit;
  logic                      out_valid;

  assign cur_bit  = lower_phase ? i_pair.lower : i_pair.upper;
  assign keep_bit = P_PUNCT_VEC[punct_idx];
  assign out_free = !out_valid || i_bit_ready;

  // A dropped bit needs no room in the output register
  assign step         = i_pair.valid && (!keep_bit || out_free);
  assign i_pair.ready = step && lower_phase;   // Pair done once its lower bit goes

  ////////////////////
  // Serializer
  ////////////////////

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n || i_clear) begin
      punct_idx   <= IDX_TOP;
      lower_phase <= 1'b0;
      out_valid   <= 1'b0;
    end else begin
      if (i_bit_ready) out_valid <= 1'b0;
      if (step) begin
        lower_phase <= !lower_phase;
        punct_idx   <= (punct_idx == '0) ? IDX_TOP : punct_idx - 1'b1;
        if (keep_bit) out_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge ce_clk) begin
    if (step && keep_bit) out_bit <= cur_bit;
  end

  assign o_bit       = out_bit;
  assign o_bit_valid = out_valid;

endmodule

//--- verilog/conv_encoder.sv
/*
  Convolutional encoder with a K-bit shift register and two XOR parity branches
  whose output stays suppressed until the register has filled
*/
`timescale 1ns/1ps

module conv_encoder #(
  parameter conv_code_pkg::code_reg_t P_G_UPPER = conv_code_pkg::DEF_G_UPPER,
  parameter conv_code_pkg::code_reg_t P_G_LOWER = conv_code_pkg::DEF_G_LOWER
) (
  input  logic      ce_clk,
  input  logic      i_rst_n,
  input  logic      i_clear,
  input  logic      i_bit,
  input  logic      i_bit_valid,
  output logic      o_bit_ready,
  coded_pair_if.enc o_pair
);

  localparam int K = conv_code_pkg::CODE_K;

  conv_code_pkg::code_reg_t code_reg;
  conv_code_pkg::code_reg_t code_next;
  conv_code_pkg::warm_cnt_t warm_cnt;
  logic                     pair_valid;
  logic                     pair_upper;
  logic                     pair_lower;
  logic                     take_bit;
  logic                     warm_done;

  // Accept a bit only if the pair register is free or draining
  assign o_bit_ready = !pair_valid || o_pair.ready;
  assign take_bit    = i_bit_valid && o_bit_ready;

  assign code_next = {code_reg[K-2:0], i_bit};  // Newest bit enters at bit 0
  assign warm_done = (warm_cnt == conv_code_pkg::warm_cnt_t'(K - 1));

  ////////////////////
  // Shift register
  ////////////////////

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n || i_clear) begin
      code_reg   <= '0;
      warm_cnt   <= '0;
      pair_valid <= 1'b0;
    end else begin
      if (o_pair.ready) pair_valid <= 1'b0;    // Pair handed to the puncturer
      if (take_bit) begin
        code_reg <= code_next;
        if (warm_done) begin
          pair_valid <= 1'b1;
        end else begin
          warm_cnt <= warm_cnt + 1'b1;         // Still filling so no output yet
        end
      end
    end
  end

  // Parity of the register after the new bit is in
  always_ff @(posedge ce_clk) begin
    if (take_bit && warm_done) begin
      pair_upper <= ^(code_next & P_G_UPPER);
      pair_lower <= ^(code_next & P_G_LOWER);
    end
  end

  assign o_pair.upper = pair_upper;
  assign o_pair.lower = pair_lower;
  assign o_pair.valid = pair_valid;

endmodule

//--- verilog/word_unpacker.sv
/*
  Word unpacker that takes 32-bit payload words and shifts them out one bit
  at a time, MSB first or LSB first
*/
`timescale 1ns/1ps

module word_unpacker (
  input  logic                      ce_clk,
  input  logic                      i_rst_n,
  input  logic                      i_clear,
  input  logic                      i_reverse_bits,
  input  conv_code_pkg::data_word_t i_data,
  input  logic                      i_valid,
  output logic                      o_ready,
  output logic                      o_bit,
  output logic                      o_bit_valid,
  input  logic                      i_bit_ready
);

  localparam int WORD_W = $bits(conv_code_pkg::data_word_t);

  conv_code_pkg::data_word_t word_buf;
  conv_code_pkg::data_word_t data_rev;
  conv_code_pkg::bit_cnt_t   bit_cnt;
  logic                      buf_full;
  logic                      ready_en;         // Holds ready low for a cycle after reset
  logic                      take_bit;
  logic                      last_bit;
  logic                      take_word;

  // LSB-first order is handled by flipping the word on load
  always_comb begin
    for (int n = 0; n < WORD_W; n++) begin
      data_rev[WORD_W-1-n] = i_data[n];
    end
  end

  assign take_bit  = buf_full && i_bit_ready;
  assign last_bit  = (bit_cnt == conv_code_pkg::bit_cnt_t'(WORD_W - 1));
  assign o_ready   = ready_en && (!buf_full || (i_bit_ready && last_bit));
  assign take_word = i_valid && o_ready;

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n || i_clear) begin
      ready_en <= 1'b0;
      buf_full <= 1'b0;
      bit_cnt  <= '0;
    end else begin
      ready_en <= 1'b1;
      if (take_word) begin
        buf_full <= 1'b1;
        bit_cnt  <= '0;
      end else if (take_bit) begin
        bit_cnt <= bit_cnt + 1'b1;               // Wraps to zero after the last bit
        if (last_bit) buf_full <= 1'b0;
      end
    end
  end

  // Shift buffer with the top bit going out first
  always_ff @(posedge ce_clk) begin
    if (take_word) begin
      word_buf <= i_reverse_bits ? data_rev : i_data;
    end else if (take_bit) begin
      word_buf <= {word_buf[WORD_W-2:0], 1'b0};
    end
  end

  assign o_bit       = word_buf[WORD_W-1];
  assign o_bit_valid = buf_full;

endmodule

//--- verilog/coded_pair_if.sv
/*
  Coded bit pair link between the convolutional encoder and the puncturer
*/
`timescale 1ns/1ps

interface coded_pair_if;

  logic upper;                                 // Parity of the upper branch
  logic lower;                                 // Parity of the lower branch
  logic valid;
  logic ready;

  // Encoder side
  modport enc (
    output upper,
    output lower,
    output valid,
    input  ready
  );

  // Puncturer side
  modport punct (
    input  upper,
    input  lower,
    input  valid,
    output ready
  );

endinterface

//--- verilog/symbol_map_pkg.sv
/*
  Symbol mapper definitions for the symbol width, sample table and pairing FSM states
*/
package symbol_map_pkg;

  localparam int BITS_PER_SYM = 2;             // QPSK

  // A symbol doubles as the sample table address
  typedef logic [BITS_PER_SYM-1:0] sym_t;

  typedef logic [31:0] sample_t;               // Packed I/Q output sample

  localparam int LUT_DEPTH = 4;

  // Bit pairing
  typedef enum logic {
    WAIT_FIRST,
    WAIT_SECOND
  } map_state_t;

endpackage

//--- verilog/conv_code_pkg.sv
/*
  Convolutional code definitions for the constraint length, generator taps,
  puncture pattern and the counter widths used along the encoder path
*/
package conv_code_pkg;

  ////////////////////
  // Code
  ////////////////////

  localparam int CODE_K = 7;                   // Constraint length

  typedef logic [CODE_K-1:0] code_reg_t;       // Bit 0 is the newest input bit

  // NASA standard (7, 1/2) generator taps
  localparam code_reg_t DEF_G_UPPER = 7'b1011011;
  localparam code_reg_t DEF_G_LOWER = 7'b1111001;

  ////////////////////
  // Puncturing
  ////////////////////

  localparam int PUNCT_RATE = 3;               // Rate 3/4

  typedef logic [2*PUNCT_RATE-1:0] punct_vec_t;

  // Interleaved upper/lower keep mask walked from the top bit down
  localparam punct_vec_t DEF_PUNCT_VEC = 6'b110110;

  typedef logic [2:0] punct_idx_t;

  ////////////////////
  // Input side
  ////////////////////

  typedef logic [31:0] data_word_t;
  typedef logic [4:0]  bit_cnt_t;              // Bit position within a word
  typedef logic [2:0]  warm_cnt_t;             // Counts the register fill

endpackage
